/* conv2d.f */
+incdir+src
src/conv2d_pkg.sv
src/conv2d_fifo.sv
src/conv2d_cfg_regs.sv
src/conv2d_row_pe.sv
src/conv2d_ctrl.sv
src/conv2d_compute.sv
tb/conv2d_mem.sv
tb/conv2d_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the conv2d testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

sim_out="$(verilator --binary --timing --assert -Wno-fatal \
        --top-module conv2d_tb -f conv2d.f -o conv2d_sim 2>&1 \
    && ./obj_dir/conv2d_sim 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -q "SIMULATION PASSED" && exit 0 || exit 1

/* tb/conv2d_tb.sv */
`timescale 1ns/1ps

module conv2d_tb;
    localparam int          CLK_HALF = 20;
    localparam logic [31:0] SEED     = 32'hf9cf;

    logic        clk = 1'b0;
    logic        write_counter_rst;
    logic        start;
    logic        write_stall_en;
    logic [31:0] fm_dim;
    logic [31:0] wt_offset;
    logic [31:0] ifm_offset;
    logic [31:0] ofm_offset;
    logic        idle;
    logic [31:0] req_read_addr;
    logic        req_read_addr_valid;
    logic        req_read_addr_ready;
    logic [31:0] req_read_len;
    logic [31:0] rdata;
    logic        rdata_valid;
    logic        rdata_ready;
    logic [31:0] req_write_addr;
    logic        req_write_addr_valid;
    logic        req_write_addr_ready;
    logic [31:0] req_write_len;
    logic [31:0] req_write_data;
    logic        req_write_data_valid;
    logic        req_write_data_ready;
    logic        resp_write_status;
    logic        resp_write_status_valid;
    logic        resp_write_status_ready;
    integer      seed = SEED;
    int          job_cnt = 0;
    logic [31:0] kern [9];
    logic [31:0] fmap [1024];

    always #CLK_HALF clk = ~clk;

    conv2d_compute dut (
        .clk, .write_counter_rst, .start, .idle,
        .fm_dim, .wt_offset, .ifm_offset, .ofm_offset,
        .req_read_addr, .req_read_addr_valid, .req_read_addr_ready, .req_read_len,
        .rdata, .rdata_valid, .rdata_ready,
        .req_write_addr, .req_write_addr_valid, .req_write_addr_ready, .req_write_len,
        .req_write_data, .req_write_data_valid, .req_write_data_ready,
        .resp_write_status, .resp_write_status_valid, .resp_write_status_ready
    );

    conv2d_mem #(.SEED(SEED)) u_mem (
        .clk, .write_counter_rst, .write_stall_en,
        .req_read_addr, .req_read_addr_valid, .req_read_addr_ready, .req_read_len,
        .rdata, .rdata_valid, .rdata_ready,
        .req_write_addr, .req_write_addr_valid, .req_write_addr_ready, .req_write_len,
        .req_write_data, .req_write_data_valid, .req_write_data_ready,
        .resp_write_status, .resp_write_status_valid, .resp_write_status_ready
    );

    // generous: every read and write word may take four cycles
    function automatic int job_budget(input int dim);
        return 4 * (dim + 2) * (dim + 2) + 4 * dim * dim + 100;
    endfunction

    function automatic int watchdog_cycles();
        int dims [8] = '{4, 5, 32, 32, 7, 1, 3, 2};
        int total;
        total = 50;
        for (int i = 0; i < 8; i++) begin
            total = total + job_budget(dims[i]);
        end
        return total;
    endfunction

    // plain zero-padded correlation, wraps at 32 bits
    function automatic logic [31:0] golden_px(input int dim, input int oy, input int ox);
        logic [31:0] acc;
        int          iy;
        int          ix;
        acc = '0;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                iy = oy + r - 1;
                ix = ox + c - 1;
                if (iy >= 0 && iy < dim && ix >= 0 && ix < dim) begin
                    acc = acc + kern[r*3+c] * fmap[iy*dim+ix];
                end
            end
        end
        return acc;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %h expected %h", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!idle && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!idle) begin
            $display("timeout: job did not return to idle within %0d cycles", limit);
            $display("SIMULATION FAILED");
            $fatal(1, "job timeout");
        end
    endtask

    task automatic run_job(input int dim, input bit identity);
        logic [31:0] wt_off;
        logic [31:0] ifm_off;
        logic [31:0] ofm_off;
        int          rd_base;
        int          wr_base;
        wt_off  = 32'h10 + job_cnt;
        ifm_off = 32'h200 + 3 * job_cnt;
        ofm_off = 32'h1000 + 5 * job_cnt;
        job_cnt++;
        for (int k = 0; k < 9; k++) begin
            kern[k] = identity ? ((k == 4) ? 32'd1 : 32'd0) : $random(seed);
            u_mem.poke(wt_off + k, kern[k]);
        end
        for (int i = 0; i < dim * dim; i++) begin
            fmap[i] = $random(seed);
            u_mem.poke(ifm_off + i, fmap[i]);
            u_mem.poke(ofm_off + i, ~(ofm_off + i));
        end
        rd_base = u_mem.rd_log_cnt;
        wr_base = u_mem.wr_log_cnt;
        @(posedge clk);
        fm_dim     <= dim;
        wt_offset  <= wt_off;
        ifm_offset <= ifm_off;
        ofm_offset <= ofm_off;
        start      <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_idle(job_budget(dim));
        check_value("read request count", u_mem.rd_log_cnt - rd_base, 2);
        check_value("req_read_addr kernel", u_mem.rd_log_addr[rd_base % 64], wt_off);
        check_value("req_read_len kernel", u_mem.rd_log_len[rd_base % 64], 9);
        check_value("req_read_addr map", u_mem.rd_log_addr[(rd_base + 1) % 64], ifm_off);
        check_value("req_read_len map", u_mem.rd_log_len[(rd_base + 1) % 64], dim * dim);
        check_value("write request count", u_mem.wr_log_cnt - wr_base, 1);
        check_value("req_write_addr", u_mem.wr_log_addr[wr_base % 64], ofm_off);
        check_value("req_write_len", u_mem.wr_log_len[wr_base % 64], dim * dim);
        for (int oy = 0; oy < dim; oy++) begin
            for (int ox = 0; ox < dim; ox++) begin
                check_value($sformatf("ofm[%0d][%0d]", oy, ox),
                            u_mem.peek(ofm_off + oy * dim + ox), golden_px(dim, oy, ox));
                if (identity) begin
                    check_value("identity ofm", u_mem.peek(ofm_off + oy * dim + ox),
                                fmap[oy * dim + ox]);
                end
            end
        end
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_value("idle", idle, 1'b1);
        check_value("req_read_addr_valid", req_read_addr_valid, 1'b0);
        check_value("req_write_addr_valid", req_write_addr_valid, 1'b0);
        check_value("resp_write_status_ready", resp_write_status_ready, 1'b0);
        check_value("req_write_data_valid", req_write_data_valid, 1'b0);
    endtask

    task automatic test_write_stalls();
        @(posedge clk);
        write_stall_en <= 1'b1;
        run_job(32, 1'b0);
        run_job(7, 1'b0);
        @(posedge clk);
        write_stall_en <= 1'b0;
    endtask

    initial begin
        write_counter_rst = 1'b1;
        start             = 1'b0;
        write_stall_en    = 1'b0;
        fm_dim            = 32'd1;
        wt_offset         = '0;
        ifm_offset        = '0;
        ofm_offset        = '0;
        repeat (2) @(posedge clk);
        write_counter_rst <= 1'b0;
        test_reset_state();
        run_job(4, 1'b1);
        run_job(5, 1'b0);
        run_job(32, 1'b0);
        test_write_stalls();
        // back to back, smallest map included
        run_job(1, 1'b0);
        run_job(3, 1'b0);
        run_job(2, 1'b0);
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles()) @(posedge clk);
        $display("watchdog: run took longer than the budget for all jobs");
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* tb/conv2d_mem.sv */
`timescale 1ns/1ps

module conv2d_mem #(
    parameter int          MEM_WORDS = 8192,
    parameter logic [31:0] SEED      = 32'h1
) (
    input  logic        clk,
    input  logic        write_counter_rst,
    input  logic        write_stall_en,
    input  logic [31:0] req_read_addr,
    input  logic        req_read_addr_valid,
    output logic        req_read_addr_ready,
    input  logic [31:0] req_read_len,
    output logic [31:0] rdata,
    output logic        rdata_valid,
    input  logic        rdata_ready,
    input  logic [31:0] req_write_addr,
    input  logic        req_write_addr_valid,
    output logic        req_write_addr_ready,
    input  logic [31:0] req_write_len,
    input  logic [31:0] req_write_data,
    input  logic        req_write_data_valid,
    output logic        req_write_data_ready,
    output logic        resp_write_status,
    output logic        resp_write_status_valid,
    input  logic        resp_write_status_ready
);
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] rdata_q = '0;
    logic        rdata_valid_q = 1'b0;
    logic        wd_ready_q = 1'b0;
    logic        resp_valid_q = 1'b0;
    logic        rd_addr_ready_q = 1'b0;
    logic        wr_addr_ready_q = 1'b0;
    integer      rd_seed = SEED;
    integer      wr_seed = SEED + 1;
    logic [31:0] burst_addr_q [$];
    logic [31:0] burst_len_q [$];
    logic [31:0] wdata_q [$];
    logic [31:0] rd_addr = '0;
    logic [31:0] rd_left = '0;
    logic [31:0] wr_addr = '0;
    logic [31:0] wr_len = '0;
    logic        wr_pend = 1'b0;
    // request log read back by the testbench
    logic [31:0] rd_log_addr [64];
    logic [31:0] rd_log_len [64];
    logic [31:0] wr_log_addr [64];
    logic [31:0] wr_log_len [64];
    int          rd_log_cnt = 0;
    int          wr_log_cnt = 0;

    assign req_read_addr_ready     = rd_addr_ready_q;
    assign req_write_addr_ready    = wr_addr_ready_q;
    assign resp_write_status       = 1'b1;
    assign rdata                   = rdata_q;
    assign rdata_valid             = rdata_valid_q;
    assign req_write_data_ready    = wd_ready_q;
    assign resp_write_status_valid = resp_valid_q;

    task automatic poke(input logic [31:0] addr, input logic [31:0] data);
        mem[addr % MEM_WORDS] = data;
    endtask

    function automatic logic [31:0] peek(input logic [31:0] addr);
        return mem[addr % MEM_WORDS];
    endfunction

    always @(posedge clk) begin
        if (write_counter_rst) begin
            rd_addr_ready_q <= 1'b0;
            rdata_valid_q   <= 1'b0;
            rd_left = '0;
            burst_addr_q.delete();
            burst_len_q.delete();
        end else begin
            // address ready drops at random so requests must hold
            rd_addr_ready_q <= ($random(rd_seed) & 1) != 0;
            if (req_read_addr_valid && req_read_addr_ready) begin
                burst_addr_q.push_back(req_read_addr);
                burst_len_q.push_back(req_read_len);
                rd_log_addr[rd_log_cnt % 64] = req_read_addr;
                rd_log_len[rd_log_cnt % 64]  = req_read_len;
                rd_log_cnt++;
            end
            // each word holds until taken so gaps fall between words
            if (!rdata_valid_q || rdata_ready) begin
                rdata_valid_q <= 1'b0;
                if (rd_left == 0 && burst_addr_q.size() != 0) begin
                    rd_addr = burst_addr_q.pop_front();
                    rd_left = burst_len_q.pop_front();
                end
                if (rd_left != 0 && ($random(rd_seed) & 3) != 0) begin
                    rdata_q       <= mem[rd_addr % MEM_WORDS];
                    rdata_valid_q <= 1'b1;
                    rd_addr = rd_addr + 1;
                    rd_left = rd_left - 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (write_counter_rst) begin
            wd_ready_q      <= 1'b0;
            wr_addr_ready_q <= 1'b0;
            resp_valid_q    <= 1'b0;
            wr_pend = 1'b0;
            wdata_q.delete();
        end else begin
            wd_ready_q <= write_stall_en ? (($random(wr_seed) & 3) != 0) : 1'b1;
            wr_addr_ready_q <= ($random(wr_seed) & 1) != 0;
            if (req_write_data_valid && wd_ready_q) begin
                wdata_q.push_back(req_write_data);
            end
            if (req_write_addr_valid && req_write_addr_ready) begin
                wr_addr = req_write_addr;
                wr_len  = req_write_len;
                wr_pend = 1'b1;
                wr_log_addr[wr_log_cnt % 64] = req_write_addr;
                wr_log_len[wr_log_cnt % 64]  = req_write_len;
                wr_log_cnt++;
            end
            if (resp_valid_q && resp_write_status_ready) begin
                resp_valid_q <= 1'b0;
            end
            // burst complete once the address and all its words are in
            if (wr_pend && wdata_q.size() == wr_len) begin
                for (int i = 0; i < wr_len; i++) begin
                    mem[(wr_addr + i) % MEM_WORDS] = wdata_q[i];
                end
                wdata_q.delete();
                wr_pend = 1'b0;
                resp_valid_q <= 1'b1;
            end
        end
    end

endmodule

/* src/conv2d_compute.sv */
`timescale 1ns/1ps
`include "conv2d_macros.svh"

module conv2d_compute (
    input  logic                    clk,
    input  logic                    write_counter_rst,
    input  logic                    start,
    output logic                    idle,
    input  logic [31:0]             fm_dim,
    input  logic [`CONV_AWIDTH-1:0] wt_offset,
    input  logic [`CONV_AWIDTH-1:0] ifm_offset,
    input  logic [`CONV_AWIDTH-1:0] ofm_offset,
    output logic [`CONV_AWIDTH-1:0] req_read_addr,
    output logic                    req_read_addr_valid,
    input  logic                    req_read_addr_ready,
    output logic [31:0]             req_read_len,
    input  logic [`CONV_DWIDTH-1:0] rdata,
    input  logic                    rdata_valid,
    output logic                    rdata_ready,
    output logic [`CONV_AWIDTH-1:0] req_write_addr,
    output logic                    req_write_addr_valid,
    input  logic                    req_write_addr_ready,
    output logic [31:0]             req_write_len,
    output logic [`CONV_DWIDTH-1:0] req_write_data,
    output logic                    req_write_data_valid,
    input  logic                    req_write_data_ready,
    input  logic                    resp_write_status,
    input  logic                    resp_write_status_valid,
    output logic                    resp_write_status_ready
);
    import conv2d_pkg::*;

    conv_state_e                              state;
    logic [`CONV_DWIDTH-1:0]                  in_deq_data;
    logic                                     in_deq_valid;
    logic                                     in_deq_ready;
    logic [`CONV_DWIDTH-1:0]                  out_enq_data;
    logic                                     out_enq_valid;
    logic                                     out_enq_ready;
    logic [31:0]                              cfg_fm_dim;
    logic [`CONV_AWIDTH-1:0]                  cfg_wt_offset;
    logic [`CONV_AWIDTH-1:0]                  cfg_ifm_offset;
    logic [`CONV_AWIDTH-1:0]                  cfg_ofm_offset;
    logic [31:0]                              cfg_fm_area;
    logic [31:0]                              cfg_pad_last;
    logic [`CONV_DWIDTH-1:0]                  pe_weight_data;
    logic                                     pe_weight_valid;
    logic [`CONV_DWIDTH-1:0]                  pe_fm_data;
    logic                                     pe_fm_valid;
    logic [`CONV_WT_DIM-1:0][`CONV_DWIDTH-1:0] pe_out_data;
    logic [`CONV_WT_DIM-1:0]                  pe_out_valid;
    logic [`CONV_WT_DIM-1:0][`CONV_DWIDTH-1:0] row_deq_data;
    logic [`CONV_WT_DIM-1:0]                  row_deq_valid;
    logic [`CONV_WT_DIM-1:0]                  row_deq_ready;

    conv2d_fifo #(.WIDTH(`CONV_DWIDTH), .LOGDEPTH(`CONV_IO_LOGDEPTH)) u_in_fifo (
        .clk               (clk),
        .write_counter_rst (write_counter_rst),
        .enq_valid         (rdata_valid),
        .enq_data          (rdata),
        .enq_ready         (rdata_ready),
        .deq_valid         (in_deq_valid),
        .deq_data          (in_deq_data),
        .deq_ready         (in_deq_ready)
    );

    // holds a whole map, so the write side never stalls the PEs
    conv2d_fifo #(.WIDTH(`CONV_DWIDTH), .LOGDEPTH(`CONV_IO_LOGDEPTH)) u_out_fifo (
        .clk               (clk),
        .write_counter_rst (write_counter_rst),
        .enq_valid         (out_enq_valid),
        .enq_data          (out_enq_data),
        .enq_ready         (out_enq_ready),
        .deq_valid         (req_write_data_valid),
        .deq_data          (req_write_data),
        .deq_ready         (req_write_data_ready)
    );

    conv2d_cfg_regs u_cfg (
        .clk, .write_counter_rst, .start, .state,
        .fm_dim, .wt_offset, .ifm_offset, .ofm_offset,
        .cfg_fm_dim, .cfg_wt_offset, .cfg_ifm_offset, .cfg_ofm_offset,
        .cfg_fm_area, .cfg_pad_last
    );

    conv2d_ctrl u_ctrl (
        .clk, .write_counter_rst, .start,
        .cfg_fm_dim, .cfg_wt_offset, .cfg_ifm_offset, .cfg_ofm_offset,
        .cfg_fm_area, .cfg_pad_last, .state, .idle,
        .req_read_addr, .req_read_addr_valid, .req_read_addr_ready, .req_read_len,
        .req_write_addr, .req_write_addr_valid, .req_write_addr_ready, .req_write_len,
        .resp_write_status, .resp_write_status_valid, .resp_write_status_ready,
        .in_deq_data, .in_deq_valid, .in_deq_ready,
        .pe_weight_data, .pe_weight_valid, .pe_fm_data, .pe_fm_valid,
        .row_deq_data, .row_deq_valid, .row_deq_ready,
        .out_enq_data, .out_enq_valid, .out_enq_ready
    );

    // one PE and one aligning FIFO per kernel row
    for (genvar r = 0; r < `CONV_WT_DIM; r++) begin : g_row
        conv2d_row_pe #(.ROW(r)) u_pe (
            .clk, .write_counter_rst, .cfg_fm_dim,
            .pe_weight_data, .pe_weight_valid, .pe_fm_data, .pe_fm_valid,
            .pe_out_data  (pe_out_data[r]),
            .pe_out_valid (pe_out_valid[r])
        );

        conv2d_fifo #(.WIDTH(`CONV_DWIDTH), .LOGDEPTH(`CONV_ROW_LOGDEPTH)) u_row_fifo (
            .clk               (clk),
            .write_counter_rst (write_counter_rst),
            .enq_valid         (pe_out_valid[r]),
            .enq_data          (pe_out_data[r]),
            .enq_ready         (),
            .deq_valid         (row_deq_valid[r]),
            .deq_data          (row_deq_data[r]),
            .deq_ready         (row_deq_ready[r])
        );
    end

endmodule

/* src/conv2d_ctrl.sv */
`timescale 1ns/1ps
`include "conv2d_macros.svh"

module conv2d_ctrl (
    input  logic                                      clk,
    input  logic                                      write_counter_rst,
    input  logic                                      start,
    input  logic [31:0]                               cfg_fm_dim,
    input  logic [`CONV_AWIDTH-1:0]                   cfg_wt_offset,
    input  logic [`CONV_AWIDTH-1:0]                   cfg_ifm_offset,
    input  logic [`CONV_AWIDTH-1:0]                   cfg_ofm_offset,
    input  logic [31:0]                               cfg_fm_area,
    input  logic [31:0]                               cfg_pad_last,
    output conv2d_pkg::conv_state_e                   state,
    output logic                                      idle,
    output logic [`CONV_AWIDTH-1:0]                   req_read_addr,
    output logic                                      req_read_addr_valid,
    input  logic                                      req_read_addr_ready,
    output logic [31:0]                               req_read_len,
    output logic [`CONV_AWIDTH-1:0]                   req_write_addr,
    output logic                                      req_write_addr_valid,
    input  logic                                      req_write_addr_ready,
    output logic [31:0]                               req_write_len,
    input  logic                                      resp_write_status,
    input  logic                                      resp_write_status_valid,
    output logic                                      resp_write_status_ready,
    input  logic [`CONV_DWIDTH-1:0]                   in_deq_data,
    input  logic                                      in_deq_valid,
    output logic                                      in_deq_ready,
    output logic [`CONV_DWIDTH-1:0]                   pe_weight_data,
    output logic                                      pe_weight_valid,
    output logic [`CONV_DWIDTH-1:0]                   pe_fm_data,
    output logic                                      pe_fm_valid,
    input  logic [`CONV_WT_DIM-1:0][`CONV_DWIDTH-1:0] row_deq_data,
    input  logic [`CONV_WT_DIM-1:0]                   row_deq_valid,
    output logic [`CONV_WT_DIM-1:0]                   row_deq_ready,
    output logic [`CONV_DWIDTH-1:0]                   out_enq_data,
    output logic                                      out_enq_valid,
    input  logic                                      out_enq_ready
);
    import conv2d_pkg::*;

    localparam int KSIZE = `CONV_WT_DIM * `CONV_WT_DIM;

    logic [$clog2(KSIZE)-1:0] wt_cnt;
    logic [31:0]              x_cnt;
    logic [31:0]              y_cnt;
    logic [31:0]              wr_cnt;
    logic                     wt_fire;
    logic                     wt_last;
    logic                     halo;
    logic                     fm_step;
    logic                     last_px;
    logic                     all_written;
    logic                     sum_fire;
    logic                     resp_fire;

    assign idle        = (state == ST_IDLE);
    assign wt_fire     = (state == ST_LOAD_WT) && in_deq_valid;
    assign wt_last     = wt_fire && (wt_cnt == KSIZE - 1);
    // halo pixels are made here, never read
    assign halo        = (x_cnt == '0) || (y_cnt == '0) ||
                         (x_cnt > cfg_fm_dim) || (y_cnt > cfg_fm_dim);
    assign last_px     = (x_cnt == cfg_pad_last) && (y_cnt == cfg_pad_last);
    assign fm_step     = (state == ST_LOAD_FM) && (halo || in_deq_valid);
    assign all_written = (state == ST_DRAIN) && (wr_cnt == cfg_fm_area);
    assign resp_fire   = resp_write_status_valid && resp_write_status_ready;

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_LOAD_WT;
                    end
                end
                ST_LOAD_WT: begin
                    if (wt_last) begin
                        state <= ST_LOAD_FM;
                    end
                end
                ST_LOAD_FM: begin
                    if (fm_step && last_px) begin
                        state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    if (all_written) begin
                        state <= ST_STORE;
                    end
                end
                ST_STORE: begin
                    if (resp_fire) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // counters for kernel words, padded x/y and written sums
    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            wt_cnt <= '0;
            x_cnt  <= '0;
            y_cnt  <= '0;
            wr_cnt <= '0;
        end else begin
            if (wt_fire) begin
                wt_cnt <= wt_last ? '0 : wt_cnt + 1'b1;
            end
            if (fm_step) begin
                if (x_cnt == cfg_pad_last) begin
                    x_cnt <= '0;
                    y_cnt <= (y_cnt == cfg_pad_last) ? '0 : y_cnt + 32'd1;
                end else begin
                    x_cnt <= x_cnt + 32'd1;
                end
            end
            if (state == ST_IDLE) begin
                wr_cnt <= '0;
            end else if (sum_fire) begin
                wr_cnt <= wr_cnt + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            req_read_addr_valid  <= 1'b0;
            req_write_addr_valid <= 1'b0;
        end else begin
            if ((idle && start) || wt_last) begin
                req_read_addr_valid <= 1'b1;
            end else if (req_read_addr_ready) begin
                req_read_addr_valid <= 1'b0;
            end
            if (all_written) begin
                req_write_addr_valid <= 1'b1;
            end else if (req_write_addr_ready) begin
                req_write_addr_valid <= 1'b0;
            end
        end
    end

    assign req_read_addr  = (state == ST_LOAD_WT) ? cfg_wt_offset : cfg_ifm_offset;
    assign req_read_len   = (state == ST_LOAD_WT) ? 32'(KSIZE) : cfg_fm_area;
    assign req_write_addr = cfg_ofm_offset;
    assign req_write_len  = cfg_fm_area;
    assign resp_write_status_ready = (state == ST_STORE) && !req_write_addr_valid;

    assign in_deq_ready    = (state == ST_LOAD_WT) || ((state == ST_LOAD_FM) && !halo);
    assign pe_weight_data  = in_deq_data;
    assign pe_weight_valid = wt_fire;
    assign pe_fm_data      = halo ? '0 : in_deq_data;
    assign pe_fm_valid     = fm_step;

    // row heads line up, so pop them together
    assign out_enq_valid = &row_deq_valid;
    assign sum_fire      = out_enq_valid && out_enq_ready;
    assign row_deq_ready = {`CONV_WT_DIM{sum_fire}};

    always_comb begin
        out_enq_data = '0;
        for (int r = 0; r < `CONV_WT_DIM; r++) begin
            out_enq_data = out_enq_data + row_deq_data[r];
        end
    end

    a_rd_addr_hold: assert property (@(posedge clk) disable iff (write_counter_rst)
        req_read_addr_valid && !req_read_addr_ready
        |=> req_read_addr_valid && $stable(req_read_addr));

    a_wr_addr_hold: assert property (@(posedge clk) disable iff (write_counter_rst)
        req_write_addr_valid && !req_write_addr_ready |=> req_write_addr_valid);

    // memory reports a good burst with status high
    a_wr_resp_ok: assert property (@(posedge clk) disable iff (write_counter_rst)
        resp_fire |-> resp_write_status);

endmodule

/* src/conv2d_row_pe.sv */
`timescale 1ns/1ps
`include "conv2d_macros.svh"

module conv2d_row_pe #(
    parameter int ROW = 0
) (
    input  logic                    clk,
    input  logic                    write_counter_rst,
    input  logic [31:0]             cfg_fm_dim,
    input  logic [`CONV_DWIDTH-1:0] pe_weight_data,
    input  logic                    pe_weight_valid,
    input  logic [`CONV_DWIDTH-1:0] pe_fm_data,
    input  logic                    pe_fm_valid,
    output logic [`CONV_DWIDTH-1:0] pe_out_data,
    output logic                    pe_out_valid
);
    localparam int K = `CONV_WT_DIM;

    logic [`CONV_DWIDTH-1:0] weights [K];
    logic [`CONV_DWIDTH-1:0] taps [K];
    logic [$clog2(K)-1:0]    wt_col;
    logic [$clog2(K)-1:0]    wt_row;
    logic [31:0]             px_col;
    logic [31:0]             px_row;
    logic [31:0]             pad_last;
    logic                    col_ok;
    logic                    row_ok;

    assign pad_last = cfg_fm_dim + 32'd1;

    // kernel comes row-major, every PE sees all of it
    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            wt_col <= '0;
            wt_row <= '0;
        end else if (pe_weight_valid) begin
            if (wt_col == K - 1) begin
                wt_col <= '0;
                wt_row <= (wt_row == K - 1) ? '0 : wt_row + 1'b1;
            end else begin
                wt_col <= wt_col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pe_weight_valid && wt_row == ROW) begin
            weights[wt_col] <= pe_weight_data;
        end
    end

    // taps[0] holds the newest pixel
    always_ff @(posedge clk) begin
        if (pe_fm_valid) begin
            taps[0] <= pe_fm_data;
            for (int k = 1; k < K; k++) begin
                taps[k] <= taps[k-1];
            end
        end
    end

    // position of the incoming pixel in the padded map
    assign col_ok = px_col >= K - 1;
    assign row_ok = (px_row >= ROW) && (px_row < ROW + cfg_fm_dim);

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            px_col       <= '0;
            px_row       <= '0;
            pe_out_valid <= 1'b0;
        end else begin
            pe_out_valid <= pe_fm_valid && col_ok && row_ok;
            if (pe_fm_valid) begin
                if (px_col == pad_last) begin
                    px_col <= '0;
                    px_row <= (px_row == pad_last) ? '0 : px_row + 32'd1;
                end else begin
                    px_col <= px_col + 32'd1;
                end
            end
        end
    end

    always_comb begin
        pe_out_data = '0;
        for (int k = 0; k < K; k++) begin
            pe_out_data = pe_out_data + weights[k] * taps[K-1-k];
        end
    end

endmodule

/* src/conv2d_cfg_regs.sv */
`timescale 1ns/1ps
`include "conv2d_macros.svh"

module conv2d_cfg_regs (
    input  logic                    clk,
    input  logic                    write_counter_rst,
    input  logic                    start,
    input  conv2d_pkg::conv_state_e state,
    input  logic [31:0]             fm_dim,
    input  logic [`CONV_AWIDTH-1:0] wt_offset,
    input  logic [`CONV_AWIDTH-1:0] ifm_offset,
    input  logic [`CONV_AWIDTH-1:0] ofm_offset,
    output logic [31:0]             cfg_fm_dim,
    output logic [`CONV_AWIDTH-1:0] cfg_wt_offset,
    output logic [`CONV_AWIDTH-1:0] cfg_ifm_offset,
    output logic [`CONV_AWIDTH-1:0] cfg_ofm_offset,
    output logic [31:0]             cfg_fm_area,
    output logic [31:0]             cfg_pad_last
);
    import conv2d_pkg::*;

    logic job_start;

    assign job_start = start && (state == ST_IDLE);

    // settings frozen for the whole job
    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            cfg_fm_dim     <= '0;
            cfg_wt_offset  <= '0;
            cfg_ifm_offset <= '0;
            cfg_ofm_offset <= '0;
            cfg_fm_area    <= '0;
            cfg_pad_last   <= '0;
        end else if (job_start) begin
            cfg_fm_dim     <= fm_dim;
            cfg_wt_offset  <= wt_offset;
            cfg_ifm_offset <= ifm_offset;
            cfg_ofm_offset <= ofm_offset;
            cfg_fm_area    <= fm_dim * fm_dim;
            // index of the right and bottom halo
            cfg_pad_last   <= fm_dim + 32'd1;
        end
    end

    a_fm_dim_range: assert property (@(posedge clk) disable iff (write_counter_rst)
        job_start |-> (fm_dim >= 32'd1) && (fm_dim <= `CONV_MAX_FM_DIM));

endmodule

/* src/conv2d_fifo.sv */
`timescale 1ns/1ps

module conv2d_fifo #(
    parameter int WIDTH    = 32,
    parameter int LOGDEPTH = 4
) (
    input  logic             clk,
    input  logic             write_counter_rst,
    input  logic             enq_valid,
    input  logic [WIDTH-1:0] enq_data,
    output logic             enq_ready,
    output logic             deq_valid,
    output logic [WIDTH-1:0] deq_data,
    input  logic             deq_ready
);
    localparam int DEPTH = 1 << LOGDEPTH;

    logic [WIDTH-1:0]    mem [DEPTH];
    logic [LOGDEPTH-1:0] wr_ptr;
    logic [LOGDEPTH-1:0] rd_ptr;
    logic [LOGDEPTH:0]   count;
    logic                enq_fire;
    logic                deq_fire;

    assign enq_ready = (count != (LOGDEPTH+1)'(DEPTH));
    assign deq_valid = (count != '0);
    assign deq_data  = mem[rd_ptr];
    assign enq_fire  = enq_valid && enq_ready;
    assign deq_fire  = deq_valid && deq_ready;

    always_ff @(posedge clk) begin
        if (enq_fire) begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // pointers wrap on their own at the power-of-two depth
    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + enq_fire - deq_fire;
        end
    end

    // a word offered while full must wait, row PEs cannot, so this catches overflow
    a_no_enq_when_full: assert property (@(posedge clk) disable iff (write_counter_rst)
        enq_valid && !enq_ready |=> enq_valid && $stable(enq_data));

endmodule

/* src/conv2d_pkg.sv */
package conv2d_pkg;

    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_LOAD_WT = 3'd1,
        ST_LOAD_FM = 3'd2,
        // last sums still on their way to the output queue
        ST_DRAIN   = 3'd3,
        ST_STORE   = 3'd4
    } conv_state_e;

endpackage

/* src/conv2d_macros.svh */
`ifndef CONV2D_MACROS_SVH
`define CONV2D_MACROS_SVH

`define CONV_DWIDTH 32
`define CONV_AWIDTH 32

// kernel side, also the number of row PEs
`define CONV_WT_DIM 3

`define CONV_IO_LOGDEPTH 10
// two map rows of lag at the largest map
`define CONV_ROW_LOGDEPTH 7
`define CONV_MAX_FM_DIM 32

`endif
